// ==== src/l2_trig_pkg.sv ====
package l2_trig_pkg;

    // array geometry
    localparam int N_LINK   = 4;
    localparam int N_POL    = 2;
    localparam int POL_H    = 0;
    localparam int POL_V    = 1;
    localparam int N_SECT   = 12;
    localparam int N_REGION = 4;

    // region bits per polarization, 48 in total
    localparam int SECT_BITS = N_SECT * N_REGION;
    localparam int META_W    = 64;

    // trigger word bit positions, bits 5:0 are not used
    localparam int LF_BIT  = 6;
    localparam int AUX_BIT = 7;

    // pipeline depths measured from the link input cycle
    localparam int RF_LATENCY = 3;
    localparam int META_ALIGN = 4;

    typedef struct packed {
        logic [7:0]        trig;
        logic [META_W-1:0] meta;
    } link_in_t;

    typedef link_in_t [N_LINK-1:0] link_bus_t;

    typedef logic [N_LINK-1:0][META_W-1:0] meta_bus_t;

    // sector i owns bits 4i+3:4i of its polarization
    typedef logic [N_POL-1:0][SECT_BITS-1:0] sector_map_t;

    // bit N_SECT*pol + sector
    typedef logic [N_POL*N_SECT-1:0] sector_scaler_t;

    typedef struct packed {
        logic       aux;
        logic [1:0] lf;
        logic [1:0] rf;
    } trig_src_t;

    typedef struct packed {
        trig_src_t src;
        meta_bus_t meta;
    } event_t;

endpackage

// ==== src/l2_delay_line.sv ====
`timescale 1ns/1ps

module l2_delay_line #(
    parameter int  DEPTH = 1,
    parameter type T     = logic
) (
    input  logic clk_i,
    input  logic rst_i,
    input  T     d_i,
    output T     q_o
);

    // stage 0 takes the input, the last stage drives the output
    T stage [DEPTH];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i - 1];
            end
        end
    end

    assign q_o = stage[DEPTH - 1];

    // a zero-depth line would be a plain wire and break the alignment
    generate
        if (DEPTH < 1) begin : g_depth_chk
            $error("l2_delay_line: DEPTH must be at least 1, got %0d", DEPTH);
        end
    endgenerate

endmodule

// ==== src/l2_sector_coinc.sv ====
`timescale 1ns/1ps

module l2_sector_coinc import l2_trig_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_i,
    input  link_bus_t      links_i,
    output logic [1:0]     rf_o,
    output sector_scaler_t scaler_o
);

    // link feeding sectors 0..5 and sectors 6..11 of each polarization
    localparam int FIRST_LINK  [N_POL] = '{POL_H: 0, POL_V: 3};
    localparam int SECOND_LINK [N_POL] = '{POL_H: 1, POL_V: 2};

    sector_map_t    low_map, high_map;
    sector_map_t    low_r, high_r;
    sector_map_t    low_rd, high_rd;
    sector_map_t    low_s, high_s;
    sector_map_t    high_rot;
    sector_map_t    coinc_q;
    sector_scaler_t sect_hit;
    sector_scaler_t hit_r, hit_rr;
    sector_scaler_t scaler_q;

    // sector order runs outward from the seam between the two links
    always_comb begin
        int lnk;
        int byt;
        for (int p = 0; p < N_POL; p++) begin
            for (int s = 0; s < N_SECT; s++) begin
                if (s < N_SECT / 2) begin
                    lnk = FIRST_LINK[p];
                    byt = N_SECT / 2 - 1 - s;
                end else begin
                    lnk = SECOND_LINK[p];
                    byt = s - N_SECT / 2;
                end
                // low nibble is the low threshold, high nibble the high one
                low_map[p][N_REGION*s +: N_REGION]  = links_i[lnk].meta[8*byt +: N_REGION];
                high_map[p][N_REGION*s +: N_REGION] = links_i[lnk].meta[8*byt+4 +: N_REGION];
            end
        end
    end

    // each sector sees the high regions of the next sector up, 11 wraps to 0
    always_comb begin
        for (int p = 0; p < N_POL; p++) begin
            high_rot[p] = {high_s[p][N_REGION-1:0], high_s[p][SECT_BITS-1:N_REGION]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            low_r   <= '0;
            high_r  <= '0;
            low_rd  <= '0;
            high_rd <= '0;
            low_s   <= '0;
            high_s  <= '0;
            coinc_q <= '0;
        end else begin
            // t+1: mapped nibbles
            low_r   <= low_map;
            high_r  <= high_map;
            low_rd  <= low_r;
            high_rd <= high_r;
            // t+2: two-cycle stretch
            low_s   <= low_r | low_rd;
            high_s  <= high_r | high_rd;
            // t+3: neighbour coincidence
            coinc_q <= low_s & high_rot;
        end
    end

    always_comb begin
        for (int p = 0; p < N_POL; p++) begin
            rf_o[p] = |coinc_q[p];
            for (int s = 0; s < N_SECT; s++) begin
                sect_hit[N_SECT*p + s] = |coinc_q[p][N_REGION*s +: N_REGION];
            end
        end
    end

    // rising edge of a sector's coincidence, pulse lands two cycles later
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hit_r    <= '0;
            hit_rr   <= '0;
            scaler_q <= '0;
        end else begin
            hit_r    <= sect_hit;
            hit_rr   <= hit_r;
            scaler_q <= hit_r & ~hit_rr;
        end
    end

    assign scaler_o = scaler_q;

endmodule

// ==== src/l2_trigger_core.sv ====
`timescale 1ns/1ps

module l2_trigger_core import l2_trig_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_i,
    input  link_bus_t      links_i,
    input  logic           holdoff_i,
    input  logic           dead_i,
    output logic           trig_o,
    output trig_src_t      src_o,
    output sector_scaler_t scaler_o
);

    typedef struct packed {
        logic       aux;
        logic [1:0] lf;
    } lfaux_t;

    lfaux_t     lfaux_next;
    lfaux_t     lfaux_r;
    lfaux_t     lfaux_dly;
    logic [1:0] rf;
    logic       trig_any;
    logic       trig_q;
    trig_src_t  src_q;

    l2_sector_coinc i_coinc (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .links_i  (links_i),
        .rf_o     (rf),
        .scaler_o (scaler_o)
    );

    // lf 0 from links 0/1, lf 1 from links 2/3, aux from any link
    always_comb begin
        lfaux_next.lf[0] = links_i[0].trig[LF_BIT] | links_i[1].trig[LF_BIT];
        lfaux_next.lf[1] = links_i[2].trig[LF_BIT] | links_i[3].trig[LF_BIT];
        lfaux_next.aux   = 1'b0;
        for (int l = 0; l < N_LINK; l++) begin
            lfaux_next.aux = lfaux_next.aux | links_i[l].trig[AUX_BIT];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lfaux_r <= '0;
        end else begin
            lfaux_r <= lfaux_next;
        end
    end

    // registered at t+1, the line brings it to t+3 next to rf
    l2_delay_line #(
        .DEPTH (RF_LATENCY - 1),
        .T     (lfaux_t)
    ) i_lfaux_dly (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .d_i   (lfaux_r),
        .q_o   (lfaux_dly)
    );

    assign trig_any = lfaux_dly.aux | (|lfaux_dly.lf) | (|rf);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            trig_q <= 1'b0;
            src_q  <= '0;
        end else begin
            trig_q    <= ~holdoff_i & ~dead_i & trig_any;
            src_q.aux <= lfaux_dly.aux;
            src_q.lf  <= lfaux_dly.lf;
            src_q.rf  <= rf;
        end
    end

    assign trig_o = trig_q;
    assign src_o  = src_q;

    // the queue relies on this to never overflow
    a_no_trig_after_dead : assert property (
        @(posedge clk_i) disable iff (rst_i) dead_i |=> !trig_o
    ) else $error("master trigger issued one cycle after dead");

endmodule

// ==== src/l2_event_queue.sv ====
`timescale 1ns/1ps

module l2_event_queue import l2_trig_pkg::*; #(
    parameter int EVENT_DEPTH = 4,
    parameter int MAX_CREDITS = 8
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      trig_i,
    input  trig_src_t src_i,
    input  meta_bus_t meta_i,
    input  logic      credit_i,
    output event_t    evt_o,
    output logic      evt_valid_o,
    output logic      dead_o
);

    localparam int PTR_W = (EVENT_DEPTH > 1) ? $clog2(EVENT_DEPTH) : 1;
    localparam int CNT_W = $clog2(EVENT_DEPTH + 1);
    localparam int CRD_W = $clog2(MAX_CREDITS + 1);

    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(EVENT_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(EVENT_DEPTH);
    localparam logic [CRD_W-1:0] CRD_MAX  = CRD_W'(MAX_CREDITS);

    event_t           mem [EVENT_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] evt_cnt;
    logic [CRD_W-1:0] crd_cnt;
    logic             full;
    logic             rd_en;

    assign full  = (evt_cnt == FULL_CNT);
    // one beat per cycle while an event and a credit are both on hand
    assign rd_en = (evt_cnt != '0) && (crd_cnt != '0);

    always_ff @(posedge clk_i) begin
        if (trig_i) begin
            mem[wr_ptr] <= '{src: src_i, meta: meta_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            evt_cnt <= '0;
        end else begin
            if (trig_i) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({trig_i, rd_en})
                2'b10:   evt_cnt <= evt_cnt + 1'b1;
                2'b01:   evt_cnt <= evt_cnt - 1'b1;
                default: evt_cnt <= evt_cnt;
            endcase
        end
    end

    // credits saturate at MAX_CREDITS and a beat with a credit cancels out
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            crd_cnt <= '0;
        end else if (credit_i && !rd_en) begin
            if (crd_cnt != CRD_MAX) begin
                crd_cnt <= crd_cnt + 1'b1;
            end
        end else if (!credit_i && rd_en) begin
            crd_cnt <= crd_cnt - 1'b1;
        end
    end

    assign evt_o       = mem[rd_ptr];
    assign evt_valid_o = rd_en;

    // the core samples dead one cycle before its trigger reaches us
    // so the last free slot being taken already counts as dead
    assign dead_o = full || ((evt_cnt == FULL_CNT - 1'b1) && trig_i);

    a_no_write_full : assert property (
        @(posedge clk_i) disable iff (rst_i) trig_i |-> !full
    ) else $error("event written while queue full");

    a_credit_cap : assert property (
        @(posedge clk_i) disable iff (rst_i) (credit_i && !rd_en) |-> (crd_cnt != CRD_MAX)
    ) else $error("credit received while the count is already at MAX_CREDITS");

endmodule

// ==== src/l2_top.sv ====
`timescale 1ns/1ps

module l2_top import l2_trig_pkg::*; #(
    parameter int EVENT_DEPTH = 4,
    parameter int MAX_CREDITS = 8
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  link_bus_t      links_i,
    input  logic           holdoff_i,
    input  logic           credit_i,
    output logic           trig_o,
    output sector_scaler_t scaler_o,
    output event_t         evt_o,
    output logic           evt_valid_o,
    output logic           dead_o
);

    meta_bus_t meta_in;
    meta_bus_t meta_aligned;
    trig_src_t src;
    logic      trig;
    logic      dead;

    for (genvar l = 0; l < N_LINK; l++) begin : g_meta
        assign meta_in[l] = links_i[l].meta;
    end

    l2_trigger_core i_core (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .links_i   (links_i),
        .holdoff_i (holdoff_i),
        .dead_i    (dead),
        .trig_o    (trig),
        .src_o     (src),
        .scaler_o  (scaler_o)
    );

    // metadata of cycle t meets the master trigger at t+4
    l2_delay_line #(
        .DEPTH (META_ALIGN),
        .T     (meta_bus_t)
    ) i_meta_dly (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .d_i   (meta_in),
        .q_o   (meta_aligned)
    );

    l2_event_queue #(
        .EVENT_DEPTH (EVENT_DEPTH),
        .MAX_CREDITS (MAX_CREDITS)
    ) i_queue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .trig_i      (trig),
        .src_i       (src),
        .meta_i      (meta_aligned),
        .credit_i    (credit_i),
        .evt_o       (evt_o),
        .evt_valid_o (evt_valid_o),
        .dead_o      (dead)
    );

    assign trig_o = trig;
    assign dead_o = dead;

endmodule

// ==== verification/tb_l2_top.sv ====
`timescale 1ns/1ps

module tb_l2_top import l2_trig_pkg::*; ();

    localparam int EVENT_DEPTH   = 4;
    localparam int MAX_CREDITS   = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int DRAIN_TIMEOUT = 200;

    // one pattern line held for cnt cycles
    typedef struct packed {
        logic [15:0]    cnt;
        link_bus_t      links;
        logic           hold;
        logic           cred;
        logic           exp_trig;
        sector_scaler_t exp_scal;
    } vec_t;

    logic           clk;
    logic           rst;
    link_bus_t      links;
    logic           holdoff;
    logic           credit;
    logic           trig;
    sector_scaler_t scaler;
    event_t         evt;
    logic           evt_valid;
    logic           dead;

    vec_t           vec_q[$];
    event_t         evt_exp_q[$];
    logic           trig_exp_q[$];
    sector_scaler_t scal_exp_q[$];
    // reference counts of stored events and unused credits
    int             queued;
    int             credits;

    l2_top #(
        .EVENT_DEPTH (EVENT_DEPTH),
        .MAX_CREDITS (MAX_CREDITS)
    ) i_dut (
        .clk_i       (clk),
        .rst_i       (rst),
        .links_i     (links),
        .holdoff_i   (holdoff),
        .credit_i    (credit),
        .trig_o      (trig),
        .scaler_o    (scaler),
        .evt_o       (evt),
        .evt_valid_o (evt_valid),
        .dead_o      (dead)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [263:0] actual,
                               input logic [263:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] t=%0t %s actual=%0h expected=%0h",
                                $time, name, actual, expected));
        end
    endtask

    function automatic logic is_idle(input vec_t v);
        return v.links == '0 && !v.hold && !v.cred && !v.exp_trig && v.exp_scal == '0;
    endfunction

    task automatic load_patterns();
        int               fd;
        int               n;
        logic [8*256-1:0] line_buf;
        logic [7:0]       tag;
        logic [15:0]      cnt;
        logic [7:0]       tv [N_LINK];
        logic [63:0]      mv [N_LINK];
        logic [4:0]       src;
        logic             hold;
        logic             cred;
        logic             etrig;
        logic [23:0]      escal;
        vec_t             v;
        event_t           e;
        fd = $fopen("verification/l2_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the pattern file");
        end
        while (!$feof(fd)) begin
            line_buf = '0;
            tag      = 8'h00;
            n        = $fgets(line_buf, fd);
            n        = $sscanf(line_buf, "%s", tag);
            if (tag == "V") begin
                n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            tag, cnt, tv[0], tv[1], tv[2], tv[3], mv[0], mv[1], mv[2],
                            mv[3], hold, cred, etrig, escal);
                if (n != 14) begin
                    abort_run("malformed vector line in the pattern file");
                end
                v.cnt = cnt;
                for (int l = 0; l < N_LINK; l++) begin
                    v.links[l].trig = tv[l];
                    v.links[l].meta = mv[l];
                end
                v.hold     = hold;
                v.cred     = cred;
                v.exp_trig = etrig;
                v.exp_scal = escal;
                vec_q.push_back(v);
            end else if (tag == "E") begin
                n = $sscanf(line_buf, "%s %h %h %h %h %h", tag, src, mv[0], mv[1], mv[2], mv[3]);
                if (n != 6) begin
                    abort_run("malformed event line in the pattern file");
                end
                e.src = src;
                for (int l = 0; l < N_LINK; l++) begin
                    e.meta[l] = mv[l];
                end
                evt_exp_q.push_back(e);
            end else if (n > 0 && tag != "#") begin
                abort_run("unknown line type in the pattern file");
            end
        end
        $fclose(fd);
    endtask

    // outputs are sampled before the new inputs go out on the same falling edge
    task automatic step_cycle(input vec_t v);
        logic exp_dead;
        logic exp_trig;
        @(negedge clk);
        exp_trig = 1'b0;
        if (trig_exp_q.size() == 4) begin
            exp_trig = trig_exp_q.pop_front();
            check_value("trig_o", trig, exp_trig);
        end
        if (scal_exp_q.size() == 5) begin
            check_value("scaler_o", scaler, scal_exp_q.pop_front());
        end
        // a trigger into the last free slot already blocks the next one
        exp_dead = (queued == EVENT_DEPTH) || (queued == EVENT_DEPTH - 1 && exp_trig);
        check_value("dead_o", dead, exp_dead);
        if (evt_valid) begin
            if (credits == 0) begin
                abort_run("event presented while no credit was available");
            end else if (evt_exp_q.size() == 0) begin
                abort_run("event presented although none was expected");
            end else begin
                check_value("evt_o", evt, evt_exp_q.pop_front());
                credits--;
                queued--;
            end
        end
        if (exp_trig) begin
            queued++;
        end
        links   = v.links;
        holdoff = v.hold;
        credit  = v.cred;
        if (v.cred && credits < MAX_CREDITS) begin
            credits++;
        end
        trig_exp_q.push_back(v.exp_trig);
        scal_exp_q.push_back(v.exp_scal);
    endtask

    initial begin
        int unsigned seed;
        int          reps;
        int          waited;
        vec_t        idle;
        seed    = 32'hca354246;
        void'($urandom(seed));
        rst     = 1'b1;
        links   = '0;
        holdoff = 1'b0;
        credit  = 1'b0;
        queued  = 0;
        credits = 0;
        idle    = '0;
        load_patterns();
        repeat (RESET_CYCLES) @(negedge clk);
        check_value("trig_o", trig, 1'b0);
        check_value("evt_valid_o", evt_valid, 1'b0);
        check_value("dead_o", dead, 1'b0);
        check_value("scaler_o", scaler, '0);
        rst = 1'b0;
        foreach (vec_q[i]) begin
            reps = vec_q[i].cnt;
            // long zero stretches may grow since nothing in flight depends on their length
            if (is_idle(vec_q[i]) && vec_q[i].cnt >= 4) begin
                reps = reps + ($urandom % 8);
            end
            repeat (reps) step_cycle(vec_q[i]);
        end
        repeat (6) step_cycle(idle);
        waited = 0;
        while (evt_exp_q.size() != 0) begin
            if (waited == DRAIN_TIMEOUT) begin
                abort_run("timeout waiting for the remaining expected events");
            end
            step_cycle(idle);
            waited++;
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
src/l2_trig_pkg.sv
src/l2_delay_line.sv
src/l2_sector_coinc.sv
src/l2_trigger_core.sv
src/l2_event_queue.sv
src/l2_top.sv
verification/tb_l2_top.sv

// ==== verification/l2_patterns.txt ====
# V count trig0 trig1 trig2 trig3 meta0 meta1 meta2 meta3 holdoff credit exp_trig(+4) exp_scaler(+5)
# E src(aux,lf[1:0],rf[1:0]) meta0 meta1 meta2 meta3, expected events in output order
# single LF 0, LF 1 and aux pulses
V 1 40 00 00 00 A100000000000001 A200000000000002 A300000000000003 A400000000000004 0 1 1 000000
V 6 00 00 00 00 0 0 0 0 0 0 0 000000
V 1 00 00 00 40 C100000000000000 C200000000000000 C300000000000000 C400000000000000 0 1 1 000000
V 6 00 00 00 00 0 0 0 0 0 0 0 000000
V 1 00 00 80 00 D100000000000000 D200000000000000 D300000000000000 D400000000000000 0 1 1 000000
V 6 00 00 00 00 0 0 0 0 0 0 0 000000
# H low sector 2 and high sector 3 in the same cycle, stretch gives two triggers
V 1 00 00 00 00 0000000001100000 0 0 0 0 1 1 000004
V 1 00 00 00 00 0 0 0 0 0 1 1 000000
V 6 00 00 00 00 0 0 0 0 0 0 0 000000
# V low sector 8, high sector 9 one cycle later
V 1 00 00 00 00 0 0 0000000000040000 0 0 0 0 000000
V 1 00 00 00 00 0 0 0000000040000000 0 0 1 1 100000
V 6 00 00 00 00 0 0 0 0 0 0 0 000000
# H low sector 11, high sector 0 one cycle later
V 1 00 00 00 00 0 0000010000000000 0 0 0 0 0 000000
V 1 00 00 00 00 0000100000000000 0 0 0 0 1 1 000800
V 6 00 00 00 00 0 0 0 0 0 0 0 000000
# low alone and high in non-neighbouring sectors
V 1 00 00 00 00 0000001001000010 0 0 0000000000000F0F 0 0 0 000000
V 6 00 00 00 00 0 0 0 0 0 0 0 000000
# holdoff three cycles after the LF pulse
V 1 40 00 00 00 E100000000000000 0 0 0 0 0 0 000000
V 2 00 00 00 00 0 0 0 0 0 0 0 000000
V 1 00 00 00 00 0 0 0 0 1 0 0 000000
V 6 00 00 00 00 0 0 0 0 0 0 0 000000
# five triggers without credits, the fifth meets dead
V 1 40 00 00 00 B100000000000000 0 0 0 0 0 1 000000
V 1 00 00 00 00 0 0 0 0 0 0 0 000000
V 1 00 00 80 00 B200000000000000 0 0 0 0 0 1 000000
V 1 00 00 00 00 0 0 0 0 0 0 0 000000
V 1 00 00 00 40 B300000000000000 0 0 0 0 0 1 000000
V 1 00 00 00 00 0 0 0 0 0 0 0 000000
V 1 00 40 00 00 B400000000000000 0 0 0 0 0 1 000000
V 1 00 00 00 00 0 0 0 0 0 0 0 000000
V 1 80 00 00 00 B500000000000000 0 0 0 0 0 0 000000
V 6 00 00 00 00 0 0 0 0 0 0 0 000000
V 2 00 00 00 00 0 0 0 0 0 1 0 000000
V 6 00 00 00 00 0 0 0 0 0 0 0 000000
V 2 00 00 00 00 0 0 0 0 0 1 0 000000
V 8 00 00 00 00 0 0 0 0 0 0 0 000000
E 04 A100000000000001 A200000000000002 A300000000000003 A400000000000004
E 08 C100000000000000 C200000000000000 C300000000000000 C400000000000000
E 10 D100000000000000 D200000000000000 D300000000000000 D400000000000000
E 01 0000000001100000 0 0 0
E 01 0 0 0 0
E 02 0 0 0000000040000000 0
E 01 0000100000000000 0 0 0
E 04 B100000000000000 0 0 0
E 10 B200000000000000 0 0 0
E 08 B300000000000000 0 0 0
E 04 B400000000000000 0 0 0
